/* mix_shift_top.f */
+incdir+.
mix_pkg.sv
mix_shift_if.sv
mix_shift.sv
mix_regs.sv
mix_shift_ctrl.sv
mix_shift_top.sv
tb_clk_gen.sv
mix_shift_assertions.sv
mix_shift_tb.sv

/* mix_shift_tb.sv */
`timescale 1ns/1ps
`include "mix_defs.svh"

module mix_shift_tb import mix_pkg::*; ();

	logic clk;
	logic reset;
	logic cmd_valid;
	cmd_kind_t cmd_kind;
	logic [`MIX_MAG_W:0] cmd_word;
	logic cmd_credit;
	logic res_valid;
	logic [`MIX_MAG_W:0] res_a;
	logic [`MIX_MAG_W:0] res_x;
	logic res_credit = 1'b0;

	int errors;
	int sent;
	int cred_back; // cmd_credit pulses seen
	int owed; // result credits not yet returned
	int res_seen;
	int cycles;
	int seen0;
	bit hold;
	string test_name;
	logic [`MIX_MAG_W:0] ma;
	logic [`MIX_MAG_W:0] mx;
	logic [`MIX_MAG_W:0] exp_a_q [$];
	logic [`MIX_MAG_W:0] exp_x_q [$];
	string name_q [$];

	tb_clk_gen u_clk (.clk(clk));

	mix_shift_top uut (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_kind(cmd_kind),
		.cmd_word(cmd_word),
		.cmd_credit(cmd_credit),
		.res_valid(res_valid),
		.res_a(res_a),
		.res_x(res_x),
		.res_credit(res_credit)
	);

	// byte 0 is the top byte of A, byte 9 the bottom byte of X
	function automatic logic [59:0] model_shift(input shift_kind_t k, input int m,
			input logic [59:0] p);
		logic [59:0] r;
		int n;
		int s;
		r = '0;
		n = (k == SLA || k == SRA) ? 5 : 10;
		for (int i = 0; i < n; i++) begin
			case (k)
				SLA, SLAX: s = i + m;
				SRA, SRAX: s = i - m;
				SLC: s = (i + m) % 10;
				default: s = (i - m % 10 + 10) % 10;
			endcase
			if (s >= 0 && s < n)
				r[59-6*i -: 6] = p[59-6*s -: 6];
		end
		if (n == 5)
			r[29:0] = p[29:0]; // X untouched
		return r;
	endfunction

	task automatic check(input string name, input logic [`MIX_MAG_W:0] exp,
			input logic [`MIX_MAG_W:0] act);
		assert (act === exp)
		else begin
			errors++;
			$display("ERROR %s: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic send(input cmd_kind_t k, input logic [`MIX_MAG_W:0] w);
		@(negedge clk);
		while (`MIX_CMD_DEPTH + cred_back - sent == 0) begin
			cmd_valid = 1'b0;
			@(negedge clk);
		end
		cmd_valid = 1'b1;
		cmd_kind = k;
		cmd_word = w;
		sent++;
	endtask

	task automatic load(input cmd_kind_t k, input logic [`MIX_MAG_W:0] v);
		if (k == LOAD_A)
			ma = v;
		else
			mx = v;
		send(k, v);
	endtask

	task automatic shift_cmd(input int f, input int m, input int c = `MIX_OP_SHIFT);
		logic [`MIX_MAG_W:0] w;
		logic [59:0] p;
		w = {1'($urandom), 12'(m), 6'($urandom), 6'(f), 6'(c)}; // I field is noise
		if (c == `MIX_OP_SHIFT && f <= 5) begin
			p = model_shift(shift_kind_t'(f), m, {ma[29:0], mx[29:0]});
			ma[29:0] = p[59:30];
			mx[29:0] = p[29:0];
			exp_a_q.push_back(ma);
			exp_x_q.push_back(mx);
			name_q.push_back(test_name);
		end
		send(EXEC, w);
	endtask

	task automatic drain();
		@(negedge clk);
		cmd_valid = 1'b0;
		while (exp_a_q.size() != 0 || owed != 0 || cred_back != sent)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	always @(posedge clk) begin
		if (!reset && cmd_credit)
			cred_back++;
	end

	always @(negedge clk) begin : monitor
		string nm;
		res_credit = 1'b0;
		if (!reset && res_valid) begin
			res_seen++;
			owed++;
			assert (exp_a_q.size() != 0)
			else begin
				errors++;
				$display("a result was reported with no shift pending");
			end
			if (exp_a_q.size() != 0) begin
				nm = name_q.pop_front();
				check({nm, " A"}, exp_a_q.pop_front(), res_a);
				check({nm, " X"}, exp_x_q.pop_front(), res_x);
			end
		end
		if (owed > 0 && !hold && $urandom_range(3) != 0) begin
			res_credit = 1'b1; // sometimes held back
			owed--;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > 40 * sent + 200) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		void'($urandom(18793));
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_kind = LOAD_A;
		cmd_word = '0;
		ma = '0;
		mx = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_name = "sla_sra";
		load(LOAD_X, 31'($urandom));
		for (int m = 0; m < 8; m++) begin
			load(LOAD_A, 31'($urandom));
			shift_cmd(SLA, m);
			load(LOAD_A, 31'($urandom));
			shift_cmd(SRA, m);
		end
		load(LOAD_A, 31'($urandom));
		shift_cmd(SLA, 6 + $urandom_range(4089));
		load(LOAD_A, 31'($urandom));
		shift_cmd(SRA, 6 + $urandom_range(4089));
		test_name = "slax_srax";
		for (int m = 0; m < 12; m++) begin
			load(LOAD_A, 31'($urandom));
			load(LOAD_X, 31'($urandom));
			shift_cmd(SLAX, m);
			load(LOAD_A, 31'($urandom));
			load(LOAD_X, 31'($urandom));
			shift_cmd(SRAX, m);
		end
		test_name = "slc_src";
		load(LOAD_A, {1'b1, 30'($urandom)});
		load(LOAD_X, {1'b0, 30'($urandom)});
		for (int i = 0; i < 20; i++) begin
			shift_cmd(SLC + (i % 2), $urandom_range(4095));
			shift_cmd(SRC - (i % 2), 10 * $urandom_range(409)); // multiples of 10
		end
		test_name = "illegal";
		shift_cmd(SLA, 1, 7);
		shift_cmd(6, 2);
		shift_cmd(7, 3);
		shift_cmd(SRA, 1, 0);
		shift_cmd(SLA, 0); // reports A and X as left
		drain();
		test_name = "backpressure";
		hold = 1'b1;
		seen0 = res_seen;
		repeat (6) shift_cmd(SRC, $urandom_range(4095));
		@(negedge clk);
		cmd_valid = 1'b0;
		repeat (30) @(negedge clk);
		check("backpressure results", `MIX_RES_CREDITS, 31'(res_seen - seen0));
		check("backpressure cmd credits", 0, 31'(`MIX_CMD_DEPTH + cred_back - sent));
		hold = 1'b0;
		drain();
		$display("errors: %0d, assertion failures: %0d", errors, uut.u_assert.fail_cnt);
		if (errors == 0 && uut.u_assert.fail_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* mix_shift_assertions.sv */
`timescale 1ns/1ps
`include "mix_defs.svh"

module mix_shift_assertions (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input logic cmd_credit,
	input logic res_valid,
	input logic res_credit,
	input logic start,
	input logic done
);

	int res_cred; // credits the DUT holds
	int acc_cnt;
	int cred_cnt;
	int fail_cnt;
	bit reset_q;

	always @(posedge clk) begin
		reset_q <= reset;
		if (reset) begin
			res_cred <= `MIX_RES_CREDITS;
			acc_cnt <= 0;
			cred_cnt <= 0;
		end else begin
			res_cred <= res_cred + int'(res_credit) - int'(res_valid);
			acc_cnt <= acc_cnt + int'(cmd_valid);
			cred_cnt <= cred_cnt + int'(cmd_credit);
		end
	end

	a_start_done: assert property (@(posedge clk) disable iff (reset) start |=> done)
		else begin
			$error("done missing one cycle after start");
			fail_cnt++;
		end

	a_done_start: assert property (@(posedge clk) disable iff (reset) done |-> $past(start))
		else begin
			$error("done without start one cycle earlier");
			fail_cnt++;
		end

	a_done_res: assert property (@(posedge clk) disable iff (reset) done |=> res_valid)
		else begin
			$error("res_valid missing one cycle after done");
			fail_cnt++;
		end

	a_res_done: assert property (@(posedge clk) disable iff (reset) res_valid |-> $past(done))
		else begin
			$error("res_valid without done one cycle earlier");
			fail_cnt++;
		end

	a_res_cred: assert property (@(posedge clk) disable iff (reset) res_valid |-> res_cred > 0)
		else begin
			$error("result sent with no result credit left");
			fail_cnt++;
		end

	a_cmd_cred: assert property (@(posedge clk) disable iff (reset)
		cmd_credit |-> cred_cnt < acc_cnt)
		else begin
			$error("more command credits returned than commands accepted");
			fail_cnt++;
		end

	// first edge of reset has no settled outputs yet
	a_reset_quiet: assert property (@(posedge clk)
		(reset && reset_q) |-> !cmd_credit && !res_valid)
		else begin
			$error("cmd_credit or res_valid high during reset");
			fail_cnt++;
		end

endmodule

bind mix_shift_top mix_shift_assertions u_assert (
	.clk(clk),
	.reset(reset),
	.cmd_valid(cmd_valid),
	.cmd_credit(cmd_credit),
	.res_valid(res_valid),
	.res_credit(res_credit),
	.start(sh_if.start),
	.done(sh_if.done)
);

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;

endmodule

/* mix_shift_top.sv */
`timescale 1ns/1ps
`include "mix_defs.svh"

module mix_shift_top import mix_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input cmd_kind_t cmd_kind,
	input logic [`MIX_MAG_W:0] cmd_word,
	output logic cmd_credit,
	output logic res_valid,
	output logic [`MIX_MAG_W:0] res_a,
	output logic [`MIX_MAG_W:0] res_x,
	input logic res_credit
);

	logic load_a;
	logic load_x;
	logic shift_we;
	mix_word_t load_word;
	mix_word_t reg_a;
	mix_word_t reg_x;

	mix_shift_if sh_if ();

	mix_shift_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_kind(cmd_kind),
		.cmd_word(cmd_word),
		.cmd_credit(cmd_credit),
		.res_credit(res_credit),
		.res_valid(res_valid),
		.load_a(load_a),
		.load_x(load_x),
		.load_word(load_word),
		.shift_we(shift_we),
		.reg_a(reg_a),
		.reg_x(reg_x),
		.sh(sh_if.ctrl)
	);

	mix_regs u_regs (
		.clk(clk),
		.reset(reset),
		.load_a(load_a),
		.load_x(load_x),
		.load_word(load_word),
		.shift_we(shift_we),
		.shift_a(sh_if.out_a),
		.shift_x(sh_if.out_x),
		.reg_a(reg_a),
		.reg_x(reg_x)
	);

	mix_shift u_shift (
		.clk(clk),
		.reset(reset),
		.sh(sh_if.core)
	);

	assign res_a = reg_a; // already written when res_valid rises
	assign res_x = reg_x;

endmodule

/* mix_shift_ctrl.sv */
`timescale 1ns/1ps
`include "mix_defs.svh"

module mix_shift_ctrl import mix_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input cmd_kind_t cmd_kind,
	input mix_word_t cmd_word,
	output logic cmd_credit,
	input logic res_credit,
	output logic res_valid,
	output logic load_a,
	output logic load_x,
	output mix_word_t load_word,
	output logic shift_we,
	input mix_word_t reg_a,
	input mix_word_t reg_x,
	mix_shift_if.ctrl sh
);

	localparam int DEPTH = `MIX_CMD_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int RC_W = $clog2(`MIX_RES_CREDITS + 1);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_ISSUE = 2'd1;
	localparam logic [1:0] S_WAIT = 2'd2;
	localparam logic [1:0] S_REPORT = 2'd3;

	cmd_kind_t q_kind [DEPTH];
	mix_word_t q_word [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] q_cnt;
	logic [RC_W-1:0] res_cred;
	logic [1:0] state;
	mix_word_t cur_word;

	cmd_kind_t head_kind;
	mix_word_t head_word;
	logic head_legal;
	logic head_shift;
	logic pop;

	assign head_kind = q_kind[rd_ptr];
	assign head_word = q_word[rd_ptr];
	assign head_legal = head_word.instr.c == `MIX_OP_SHIFT && head_word.instr.f <= 6'(SRC);
	assign head_shift = head_kind == EXEC && head_legal;
	// illegal words and loads need no result credit
	assign pop = state == S_IDLE && q_cnt != '0 && (!head_shift || res_cred != '0);

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			q_kind[wr_ptr] <= cmd_kind;
			q_word[wr_ptr] <= cmd_word;
		end
		if (pop)
			cur_word <= head_word;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_cnt <= '0;
			res_cred <= RC_W'(`MIX_RES_CREDITS);
			state <= S_IDLE;
			cmd_credit <= 1'b0;
			load_a <= 1'b0;
			load_x <= 1'b0;
		end else begin
			if (cmd_valid)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			q_cnt <= q_cnt + CNT_W'(cmd_valid) - CNT_W'(pop);
			res_cred <= res_cred + RC_W'(res_credit) - RC_W'(res_valid);
			cmd_credit <= pop; // every pop frees a slot
			load_a <= pop && head_kind == LOAD_A;
			load_x <= pop && head_kind == LOAD_X;
			case (state)
				S_IDLE: if (pop && head_shift) state <= S_ISSUE;
				S_ISSUE: state <= S_WAIT;
				S_WAIT: if (sh.done) state <= S_REPORT;
				S_REPORT: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	assign res_valid = state == S_REPORT;
	assign shift_we = sh.done;
	assign load_word.data = cur_word.data;

	assign sh.start = state == S_ISSUE;
	assign sh.kind = shift_kind_t'(cur_word.instr.f[2:0]);
	assign sh.count = cur_word.instr.addr; // magnitude only
	assign sh.in_a = reg_a.data.mag;
	assign sh.in_x = reg_x.data.mag;

endmodule

/* mix_regs.sv */
`timescale 1ns/1ps
`include "mix_defs.svh"

module mix_regs import mix_pkg::*; (
	input logic clk,
	input logic reset,
	input logic load_a,
	input logic load_x,
	input mix_word_t load_word,
	input logic shift_we,
	input logic [`MIX_MAG_W-1:0] shift_a,
	input logic [`MIX_MAG_W-1:0] shift_x,
	output mix_word_t reg_a,
	output mix_word_t reg_x
);

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_a <= '0;
			reg_x <= '0;
		end else if (shift_we) begin
			reg_a.data.mag <= shift_a; // signs stay
			reg_x.data.mag <= shift_x;
		end else begin
			if (load_a)
				reg_a.data <= load_word.data;
			if (load_x)
				reg_x.data <= load_word.data;
		end
	end

endmodule

/* mix_shift.sv */
`timescale 1ns/1ps
`include "mix_defs.svh"

module mix_shift import mix_pkg::*; (
	input logic clk,
	input logic reset,
	mix_shift_if.core sh
);

	localparam int BW = `MIX_BYTE_W;
	localparam int MW = `MIX_MAG_W;
	localparam int PW = 2 * MW;

	logic odd;
	logic [2:0] cls;
	logic [4:0] bit_oh [1:`MIX_CNT_W-1];
	logic [4:0] grp_oh [0:3];
	logic [4:0] res_oh;

	logic done_q;
	logic sla_q;
	logic sra_q;
	logic slax_q;
	logic srax_q;
	logic slc_q;
	logic src_q;
	logic [2:0] cls_q;
	logic [4:0] rot_q;
	logic [MW-1:0] a1_q;
	logic [MW-1:0] x1_q;

	logic [PW-1:0] pair1;
	logic [2*PW-1:0] dbl;
	logic [PW-1:0] pair_out;

	// one-hot residues are indexed in steps of 2, so bit k means 2k mod 10
	function automatic logic [4:0] oh_add(input logic [4:0] p, input logic [4:0] q);
		logic [4:0] r;
		r = '0;
		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 5; j++) begin
				if (p[i] && q[j])
					r[(i + j) % 5] = 1'b1;
			end
		end
		return r;
	endfunction

	assign odd = sh.count[0];
	// pairs of bytes beyond the odd one, 5 means too far
	assign cls = (sh.count[`MIX_CNT_W-1:1] < 5) ? sh.count[3:1] : 3'd5;

	for (genvar i = 1; i < `MIX_CNT_W; i++) begin : g_bit_res
		localparam int HALF = ((2 ** i) % 10) / 2; // 2^i mod 10, halved
		assign bit_oh[i] = sh.count[i] ? 5'(1 << HALF) : 5'b00001;
	end

	// layer 1 over bit triples, layer 2 folds the groups
	assign grp_oh[0] = oh_add(oh_add(bit_oh[1], bit_oh[2]), bit_oh[3]);
	assign grp_oh[1] = oh_add(oh_add(bit_oh[4], bit_oh[5]), bit_oh[6]);
	assign grp_oh[2] = oh_add(oh_add(bit_oh[7], bit_oh[8]), bit_oh[9]);
	assign grp_oh[3] = oh_add(bit_oh[10], bit_oh[11]);
	assign res_oh = oh_add(oh_add(grp_oh[0], grp_oh[1]), oh_add(grp_oh[2], grp_oh[3]));

	always_ff @(posedge clk) begin
		if (reset) begin
			done_q <= 1'b0;
			sla_q <= 1'b0;
			sra_q <= 1'b0;
			slax_q <= 1'b0;
			srax_q <= 1'b0;
			slc_q <= 1'b0;
			src_q <= 1'b0;
		end else begin
			done_q <= sh.start;
			sla_q <= sh.start && sh.kind == SLA;
			sra_q <= sh.start && sh.kind == SRA;
			slax_q <= sh.start && sh.kind == SLAX;
			srax_q <= sh.start && sh.kind == SRAX;
			slc_q <= sh.start && sh.kind == SLC;
			src_q <= sh.start && sh.kind == SRC;
		end
	end

	// stage 1, the odd byte
	always_ff @(posedge clk) begin
		cls_q <= cls;
		rot_q <= res_oh;
		a1_q <= sh.in_a;
		x1_q <= sh.in_x;
		if (odd) begin
			case (sh.kind)
				SLA: a1_q <= {sh.in_a[MW-BW-1:0], {BW{1'b0}}};
				SRA: a1_q <= {{BW{1'b0}}, sh.in_a[MW-1:BW]};
				SLAX: begin
					a1_q <= {sh.in_a[MW-BW-1:0], sh.in_x[MW-1:MW-BW]};
					x1_q <= {sh.in_x[MW-BW-1:0], {BW{1'b0}}};
				end
				SRAX: begin
					a1_q <= {{BW{1'b0}}, sh.in_a[MW-1:BW]};
					x1_q <= {sh.in_a[BW-1:0], sh.in_x[MW-1:BW]};
				end
				SLC: begin
					a1_q <= {sh.in_a[MW-BW-1:0], sh.in_x[MW-1:MW-BW]};
					x1_q <= {sh.in_x[MW-BW-1:0], sh.in_a[MW-1:MW-BW]};
				end
				SRC: begin
					a1_q <= {sh.in_x[BW-1:0], sh.in_a[MW-1:BW]};
					x1_q <= {sh.in_a[BW-1:0], sh.in_x[MW-1:BW]};
				end
				default: ;
			endcase
		end
	end

	// stage 2, the even part of the move
	always_comb begin
		int amt;
		int rot_i;
		amt = 2 * BW * cls_q; // class 5 clears everything
		rot_i = 0;
		for (int i = 0; i < 5; i++) begin
			if (rot_q[i])
				rot_i = i;
		end
		if (src_q)
			rot_i = (5 - rot_i) % 5; // right rotate as left
		pair1 = {a1_q, x1_q};
		dbl = {pair1, pair1} << (2 * BW * rot_i);
		pair_out = pair1;
		if (sla_q)
			pair_out = {a1_q << amt, x1_q};
		else if (sra_q)
			pair_out = {a1_q >> amt, x1_q};
		else if (slax_q)
			pair_out = pair1 << amt;
		else if (srax_q)
			pair_out = pair1 >> amt;
		else if (slc_q || src_q)
			pair_out = dbl[2*PW-1 -: PW];
	end

	assign sh.out_a = pair_out[PW-1:MW];
	assign sh.out_x = pair_out[MW-1:0];
	assign sh.done = done_q;

endmodule

/* mix_shift_if.sv */
`timescale 1ns/1ps
`include "mix_defs.svh"

interface mix_shift_if import mix_pkg::*; ();

	logic start;
	shift_kind_t kind;
	logic [`MIX_CNT_W-1:0] count;
	logic [`MIX_MAG_W-1:0] in_a;
	logic [`MIX_MAG_W-1:0] in_x;
	logic [`MIX_MAG_W-1:0] out_a; // valid with done only
	logic [`MIX_MAG_W-1:0] out_x;
	logic done;

	modport ctrl (
		output start,
		output kind,
		output count,
		output in_a,
		output in_x,
		input out_a,
		input out_x,
		input done
	);

	modport core (
		input start,
		input kind,
		input count,
		input in_a,
		input in_x,
		output out_a,
		output out_x,
		output done
	);

endinterface

/* mix_pkg.sv */
`include "mix_defs.svh"

package mix_pkg;

	typedef struct packed {
		logic sign;
		logic [`MIX_MAG_W-1:0] mag;
	} mix_data_t;

	typedef struct packed {
		logic sign;
		logic [`MIX_CNT_W-1:0] addr; // shift count M
		logic [`MIX_BYTE_W-1:0] index; // ignored
		logic [`MIX_BYTE_W-1:0] f;
		logic [`MIX_BYTE_W-1:0] c;
	} mix_instr_t;

	// same 31 bits, read as data for loads and as fields for shifts
	typedef union packed {
		mix_data_t data;
		mix_instr_t instr;
	} mix_word_t;

	typedef enum logic [2:0] {
		SLA = 3'd0,
		SRA = 3'd1,
		SLAX = 3'd2,
		SRAX = 3'd3,
		SLC = 3'd4,
		SRC = 3'd5
	} shift_kind_t;

	typedef enum logic [1:0] {
		LOAD_A = 2'd0,
		LOAD_X = 2'd1,
		EXEC = 2'd2
	} cmd_kind_t;

endpackage

/* mix_defs.svh */
`ifndef MIX_DEFS_SVH
`define MIX_DEFS_SVH

// word layout
`define MIX_BYTE_W 6
`define MIX_MAG_W 30
`define MIX_CNT_W 12

// flow control
`define MIX_CMD_DEPTH 4
`define MIX_RES_CREDITS 2

// opcode C of the shift group
`define MIX_OP_SHIFT 6

`endif
